/* design/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// instruction queue entries and the producer's starting credits
`define QUEUE_DEPTH 8

// reorder buffer geometry
`define ROB_SIZE 8
`define TAG_W 3

// retire credits held after reset
`define COMMIT_CREDITS 4

// load/store side
`define LSQ_DEPTH 4
`define MEM_WORDS 16

`endif

/* design/rv_types_pkg.sv */
`default_nettype none

package rv_types_pkg;

	// selects the execution unit
	typedef enum logic [1:0] {
		op_alu    = 2'd0,
		op_branch = 2'd1,
		op_mem    = 2'd2
	} op_class_t;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_sll = 3'd5,
		alu_srl = 3'd6,
		alu_sra = 3'd7
	} alu_fn_t;

	// lt compares signed
	typedef enum logic [1:0] {
		br_eq     = 2'd0,
		br_ne     = 2'd1,
		br_lt     = 2'd2,
		br_always = 2'd3
	} br_fn_t;

	// operands come in already resolved, fn is decoded per class
	typedef struct packed {
		logic [31:0] pc;
		op_class_t   op_class;
		logic [2:0]  fn;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic        is_store;
	} uop_t;

endpackage

`default_nettype wire

/* design/ooo_pkg.sv */
`default_nettype none
`include "ooo_params.svh"

package ooo_pkg;

	import rv_types_pkg::*;

	// rdy marks a valid completion
	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic              rdy;
		logic [31:0]       data;
	} sal_t;

	typedef struct packed {
		logic        valid;
		logic        done;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic        is_store;
		logic [31:0] data;
	} rob_t;

	// rob to unit
	typedef struct packed {
		logic              valid;
		logic [`TAG_W-1:0] tag;
		uop_t              uop;
	} disp_t;

	// address already formed at dispatch
	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [31:0]       addr;
		logic [31:0]       wdata;
		logic              is_store;
	} lsq_req_t;

	typedef struct packed {
		logic [`TAG_W-1:0] tag;
		logic [31:0]       pc;
		logic [4:0]        rd;
		logic              is_store;
		logic [31:0]       data;
	} commit_t;

endpackage

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_en,
	input  payload_t wr_data,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_wr;
	logic do_rd;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	// head entry is visible without a read cycle
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
		else $error("sync_fifo: write while full");
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
		else $error("sync_fifo: read while empty");

endmodule

`default_nettype wire

/* design/rob.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_params.svh"

module rob
	import rv_types_pkg::*;
	import ooo_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  uop_t    q_uop,
	input  logic    q_empty,
	output logic    q_pop,
	input  logic    alu_ready,
	input  logic    br_ready,
	input  logic    lsq_ready,
	output disp_t   alu_disp,
	output disp_t   br_disp,
	output disp_t   lsq_disp,
	input  sal_t    alu_done,
	input  sal_t    br_done,
	input  sal_t    lsq_done,
	output logic    commit_valid,
	output commit_t commit_out,
	input  logic    commit_credit
);

	localparam int CNT_W = `TAG_W + 1;
	localparam int CRED_W = $clog2(`COMMIT_CREDITS + 1);

	rob_t arr [`ROB_SIZE];
	logic [`TAG_W-1:0] head;
	logic [`TAG_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic [CRED_W-1:0] credits;
	logic full;
	logic unit_ready;
	logic alloc;
	logic retire;
	sal_t done_bus [3];

	function automatic logic [`TAG_W-1:0] next_ptr(input logic [`TAG_W-1:0] ptr);
		return (ptr == `TAG_W'(`ROB_SIZE - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(`ROB_SIZE));

	// back-pressure from the unit this op is headed for
	always_comb begin
		case (q_uop.op_class)
			op_alu: unit_ready = alu_ready;
			op_branch: unit_ready = br_ready;
			op_mem: unit_ready = lsq_ready;
			default: unit_ready = 1'b0;
		endcase
	end

	assign alloc = !q_empty && !full && unit_ready;
	assign q_pop = alloc;

	assign alu_disp = '{valid: alloc && (q_uop.op_class == op_alu), tag: tail, uop: q_uop};
	assign br_disp = '{valid: alloc && (q_uop.op_class == op_branch), tag: tail, uop: q_uop};
	assign lsq_disp = '{valid: alloc && (q_uop.op_class == op_mem), tag: tail, uop: q_uop};

	// head goes only when finished and the consumer has room
	assign retire = arr[head].valid && arr[head].done && (credits != '0);

	assign done_bus[0] = alu_done;
	assign done_bus[1] = br_done;
	assign done_bus[2] = lsq_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			credits <= CRED_W'(`COMMIT_CREDITS);
			for (int i = 0; i < `ROB_SIZE; i++) begin
				arr[i].valid <= 1'b0;
				arr[i].done <= 1'b0;
			end
		end else begin
			if (alloc) begin
				arr[tail] <= '{
					valid: 1'b1,
					done: 1'b0,
					pc: q_uop.pc,
					rd: q_uop.rd,
					is_store: q_uop.is_store,
					data: '0
				};
				tail <= next_ptr(tail);
			end
			// up to three completions land per cycle, always on distinct tags
			for (int i = 0; i < 3; i++) begin
				if (done_bus[i].rdy) begin
					arr[done_bus[i].tag].done <= 1'b1;
					arr[done_bus[i].tag].data <= done_bus[i].data;
				end
			end
			if (retire) begin
				arr[head].valid <= 1'b0;
				head <= next_ptr(head);
			end
			count <= count + CNT_W'(alloc) - CNT_W'(retire);
			// retire and returned credit cancel
			credits <= credits - CRED_W'(retire) + CRED_W'(commit_credit);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			commit_valid <= 1'b0;
		end else begin
			commit_valid <= retire;
		end
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			commit_out <= '{
				tag: head,
				pc: arr[head].pc,
				rd: arr[head].rd,
				is_store: arr[head].is_store,
				data: arr[head].data
			};
		end
	end

	for (genvar g = 0; g < 3; g++) begin : g_done_chk
		a_done_valid: assert property (@(posedge clk) disable iff (rst)
			done_bus[g].rdy |-> arr[done_bus[g].tag].valid)
			else $error("rob: completion for a free entry");
	end

	a_credit_max: assert property (@(posedge clk) disable iff (rst)
		credits <= CRED_W'(`COMMIT_CREDITS))
		else $error("rob: commit credits above limit");

endmodule

`default_nettype wire

/* design/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_params.svh"

module alu_unit
	import rv_types_pkg::*;
	import ooo_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  disp_t disp,
	output sal_t  done
);

	logic [31:0] result;
	logic vld_q;
	logic [`TAG_W-1:0] tag_q;
	logic [31:0] data_q;

	always_comb begin
		case (alu_fn_t'(disp.uop.fn))
			alu_add: result = disp.uop.a + disp.uop.b;
			alu_sub: result = disp.uop.a - disp.uop.b;
			alu_and: result = disp.uop.a & disp.uop.b;
			alu_or: result = disp.uop.a | disp.uop.b;
			alu_xor: result = disp.uop.a ^ disp.uop.b;
			// shift amount from the low five bits
			alu_sll: result = disp.uop.a << disp.uop.b[4:0];
			alu_srl: result = disp.uop.a >> disp.uop.b[4:0];
			alu_sra: result = 32'($signed(disp.uop.a) >>> disp.uop.b[4:0]);
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= disp.valid;
		end
	end

	always_ff @(posedge clk) begin
		tag_q <= disp.tag;
		data_q <= result;
	end

	assign done = '{tag: tag_q, rdy: vld_q, data: data_q};

endmodule

`default_nettype wire

/* design/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_params.svh"

module branch_unit
	import rv_types_pkg::*;
	import ooo_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  disp_t disp,
	output sal_t  done
);

	logic cond;
	logic s1_valid;
	logic s1_taken;
	logic [`TAG_W-1:0] s1_tag;
	logic [31:0] s1_pc;
	logic [31:0] s1_imm;
	logic s2_valid;
	logic [`TAG_W-1:0] s2_tag;
	logic [31:0] s2_npc;

	always_comb begin
		case (br_fn_t'(disp.uop.fn[1:0]))
			br_eq: cond = (disp.uop.a == disp.uop.b);
			br_ne: cond = (disp.uop.a != disp.uop.b);
			br_lt: cond = ($signed(disp.uop.a) < $signed(disp.uop.b));
			default: cond = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= disp.valid;
			s2_valid <= s1_valid;
		end
	end

	// stage one compares, stage two forms the target
	always_ff @(posedge clk) begin
		s1_taken <= cond;
		s1_tag <= disp.tag;
		s1_pc <= disp.uop.pc;
		s1_imm <= disp.uop.imm;
		s2_tag <= s1_tag;
		s2_npc <= s1_taken ? (s1_pc + s1_imm) : (s1_pc + 32'd4);
	end

	assign done = '{tag: s2_tag, rdy: s2_valid, data: s2_npc};

endmodule

`default_nettype wire

/* design/lsq_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_params.svh"

module lsq_unit
	import ooo_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  disp_t disp,
	output logic  ready,
	output sal_t  done
);

	localparam int IDX_W = $clog2(`MEM_WORDS);

	lsq_req_t req_in;
	lsq_req_t req_head;
	logic q_empty;
	logic q_full;
	logic [IDX_W-1:0] idx;
	logic [31:0] mem [`MEM_WORDS];
	logic vld_q;
	logic [`TAG_W-1:0] tag_q;
	logic [31:0] data_q;

	assign req_in = '{
		tag: disp.tag,
		addr: disp.uop.a + disp.uop.imm,
		wdata: disp.uop.b,
		is_store: disp.uop.is_store
	};

	// accesses leave in program order, one per cycle
	sync_fifo #(
		.DEPTH(`LSQ_DEPTH),
		.payload_t(lsq_req_t)
	) i_lsq_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(disp.valid),
		.wr_data(req_in),
		.rd_en(!q_empty),
		.rd_data(req_head),
		.empty(q_empty),
		.full(q_full)
	);

	assign ready = !q_full;

	// word address wraps over the memory
	assign idx = req_head.addr[2 +: IDX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q <= 1'b0;
			for (int i = 0; i < `MEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else begin
			vld_q <= !q_empty;
			if (!q_empty && req_head.is_store) begin
				mem[idx] <= req_head.wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		tag_q <= req_head.tag;
		data_q <= req_head.is_store ? 32'd0 : mem[idx];
	end

	assign done = '{tag: tag_q, rdy: vld_q, data: data_q};

endmodule

`default_nettype wire

/* design/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_params.svh"

module ooo_core
	import rv_types_pkg::*;
	import ooo_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    in_valid,
	input  uop_t    in_uop,
	output logic    in_credit,
	output logic    commit_valid,
	output commit_t commit_out,
	input  logic    commit_credit
);

	uop_t q_uop;
	logic q_empty;
	logic q_pop;
	logic lsq_ready;
	disp_t alu_disp;
	disp_t br_disp;
	disp_t lsq_disp;
	sal_t alu_done;
	sal_t br_done;
	sal_t lsq_done;

	// producer credits keep the queue from overflowing
	sync_fifo #(
		.DEPTH(`QUEUE_DEPTH),
		.payload_t(uop_t)
	) i_instr_q (
		.clk(clk),
		.rst(rst),
		.wr_en(in_valid),
		.wr_data(in_uop),
		.rd_en(q_pop),
		.rd_data(q_uop),
		.empty(q_empty),
		.full()
	);

	rob i_rob (
		.clk(clk),
		.rst(rst),
		.q_uop(q_uop),
		.q_empty(q_empty),
		.q_pop(q_pop),
		.alu_ready(1'b1),
		.br_ready(1'b1),
		.lsq_ready(lsq_ready),
		.alu_disp(alu_disp),
		.br_disp(br_disp),
		.lsq_disp(lsq_disp),
		.alu_done(alu_done),
		.br_done(br_done),
		.lsq_done(lsq_done),
		.commit_valid(commit_valid),
		.commit_out(commit_out),
		.commit_credit(commit_credit)
	);

	alu_unit i_alu (.clk(clk), .rst(rst), .disp(alu_disp), .done(alu_done));

	branch_unit i_branch (.clk(clk), .rst(rst), .disp(br_disp), .done(br_done));

	lsq_unit i_lsq (
		.clk(clk),
		.rst(rst),
		.disp(lsq_disp),
		.ready(lsq_ready),
		.done(lsq_done)
	);

	// one credit back per popped entry
	always_ff @(posedge clk) begin
		if (rst) begin
			in_credit <= 1'b0;
		end else begin
			in_credit <= q_pop;
		end
	end

endmodule

`default_nettype wire

/* tests/tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ooo_params.svh"

module tb_ooo_core
	import rv_types_pkg::*;
	import ooo_pkg::*;
();

	logic clk;
	logic rst;
	logic in_valid;
	uop_t in_uop;
	logic in_credit;
	logic commit_valid;
	commit_t commit_out;
	logic commit_credit;

	logic [31:0] rng;
	uop_t send_q [$];
	commit_t exp_q [$];
	logic [31:0] model_mem [`MEM_WORDS];
	logic [`TAG_W-1:0] next_tag;
	logic withhold;
	int ret_mask;
	int in_credits;
	int core_credits;
	int owed;
	int sent;
	int commits;
	int credit_pulses;
	int errors;
	int tests_run;
	int tests_failed;

	ooo_core i_ooo_core (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_uop(in_uop),
		.in_credit(in_credit),
		.commit_valid(commit_valid),
		.commit_out(commit_out),
		.commit_credit(commit_credit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic roll(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	function automatic logic [31:0] alu_expect(input logic [2:0] fn, input logic [31:0] a,
			input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (fn)
			3'd0: return a + b;
			3'd1: return a - b;
			3'd2: return a & b;
			3'd3: return a | b;
			3'd4: return a ^ b;
			3'd5: return a << b[4:0];
			3'd6: return a >> b[4:0];
			default: return sa >>> b[4:0];
		endcase
	endfunction

	function automatic logic [31:0] branch_expect(input logic [1:0] fn, input uop_t u);
		logic taken;
		case (fn)
			2'd0: taken = (u.a == u.b);
			2'd1: taken = (u.a != u.b);
			2'd2: taken = ($signed(u.a) < $signed(u.b));
			default: taken = 1'b1;
		endcase
		return taken ? u.pc + u.imm : u.pc + 32'd4;
	endfunction

	// sel 0 alu, 1 branch, 2 mem, 3 alu or branch, 4 any class
	task automatic add_op(input int sel);
		uop_t u;
		commit_t e;
		logic [31:0] r;
		logic [31:0] d;
		int cls;
		int word;
		int idx;
		u = '0;
		roll(r);
		cls = (sel == 3) ? int'(r % 2) : (sel == 4) ? int'(r % 3) : sel;
		roll(r);
		u.pc = {r[31:2], 2'b00};
		u.rd = r[8:4];
		roll(r);
		u.a = r;
		roll(r);
		// equal operands now and then so eq and ne both go both ways
		u.b = r[0] ? u.a : r;
		roll(r);
		if (cls == 0) begin
			u.op_class = op_alu;
			u.fn = r[2:0];
			d = alu_expect(u.fn, u.a, u.b);
		end else if (cls == 1) begin
			u.op_class = op_branch;
			u.fn = {1'b0, r[1:0]};
			u.imm = {{19{r[12]}}, r[12:2], 2'b00};
			d = branch_expect(r[1:0], u);
		end else begin
			u.op_class = op_mem;
			u.is_store = r[0];
			// words 16..19 alias 0..3
			word = int'(r[3:1] % 4) + (r[4] ? 16 : 0);
			u.imm = 32'(r[9:8]) << 2;
			u.a = 32'(word * 4) + 32'(r[6:5]) - u.imm;
			idx = int'(((u.a + u.imm) >> 2) % `MEM_WORDS);
			if (u.is_store) begin
				model_mem[idx] = u.b;
				d = '0;
			end else begin
				d = model_mem[idx];
			end
		end
		e = '{tag: next_tag, pc: u.pc, rd: u.rd, is_store: u.is_store, data: d};
		next_tag = (next_tag == `TAG_W'(`ROB_SIZE - 1)) ? '0 : next_tag + 1'b1;
		send_q.push_back(u);
		exp_q.push_back(e);
	endtask

	task automatic check_commit(input commit_t exp, input commit_t act);
		if (act !== exp) begin
			$display("ERROR commit_out expected %h got %h", exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	// sample outputs at the falling edge then drive the next inputs
	task automatic step();
		commit_t exp;
		logic [31:0] r;
		@(negedge clk);
		if (in_credit) begin
			in_credits++;
			credit_pulses++;
		end
		if (commit_valid) begin
			commits++;
			owed++;
			core_credits--;
			if (core_credits < 0) begin
				$display("core retired an op without holding a commit credit");
				errors++;
			end
			if (exp_q.size() == 0) begin
				$display("commit arrived with no op outstanding");
				errors++;
			end else begin
				exp = exp_q.pop_front();
				check_commit(exp, commit_out);
			end
		end
		roll(r);
		commit_credit = 1'b0;
		if (!withhold && owed > 0 && (int'(r[15:8]) & ret_mask) == 0) begin
			commit_credit = 1'b1;
			owed--;
			core_credits++;
		end
		in_valid = 1'b0;
		if (send_q.size() > 0 && in_credits > 0 && r[2:0] != 3'd0) begin
			in_uop = send_q.pop_front();
			in_valid = 1'b1;
			in_credits--;
			sent++;
		end
	endtask

	function automatic logic all_idle();
		return send_q.size() == 0 && exp_q.size() == 0 && owed == 0 &&
			in_credits == `QUEUE_DEPTH;
	endfunction

	task automatic drain(input int limit, input string what);
		int n;
		n = 0;
		while (!all_idle() && n < limit) begin
			step();
			n++;
		end
		if (!all_idle()) begin
			$display("%s did not drain within %0d cycles, %0d results missing",
				what, limit, exp_q.size());
			errors++;
		end
	endtask

	task automatic wait_sent(input int limit);
		int n;
		n = 0;
		while (send_q.size() > 0 && n < limit) begin
			step();
			n++;
		end
		if (send_q.size() > 0) begin
			$display("producer still had %0d ops unsent after %0d cycles", send_q.size(), limit);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		if (errors == err0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - err0);
		end
	endtask

	initial begin
		int err0;
		int c0;
		int p0;
		int masks [6];
		masks = '{0, 7, 3, 15, 1, 0};
		rst = 1'b1;
		in_valid = 1'b0;
		in_uop = '0;
		commit_credit = 1'b0;
		rng = 32'd71;
		next_tag = '0;
		withhold = 1'b0;
		ret_mask = 0;
		in_credits = `QUEUE_DEPTH;
		core_credits = `COMMIT_CREDITS;
		owed = 0;
		sent = 0;
		commits = 0;
		credit_pulses = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < `MEM_WORDS; i++) begin
			model_mem[i] = '0;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		err0 = errors;
		check_count("commit_valid", 0, int'(commit_valid));
		check_count("in_credit", 0, int'(in_credit));
		repeat (20) step();
		check_count("commits while idle", 0, commits);
		check_count("in_credit pulses while idle", 0, credit_pulses);
		finish_test("reset and idle", err0);

		err0 = errors;
		ret_mask = 0;
		repeat (40) add_op(3);
		drain(2000, "alu and branch run");
		finish_test("alu and branch in order", err0);

		err0 = errors;
		ret_mask = 3;
		repeat (40) add_op(2);
		drain(2000, "load and store run");
		finish_test("loads and stores", err0);

		// all credits are back with the core here
		err0 = errors;
		ret_mask = 1;
		withhold = 1'b1;
		c0 = commits;
		p0 = credit_pulses;
		repeat (12) add_op(4);
		repeat (80) step();
		check_count("commits while withheld", `COMMIT_CREDITS, commits - c0);
		check_count("in_credit pulses while withheld", 12, credit_pulses - p0);
		withhold = 1'b0;
		drain(2000, "withheld credit run");
		finish_test("commit back-pressure", err0);

		err0 = errors;
		for (int i = 0; i < 6; i++) begin
			ret_mask = masks[i];
			repeat (50) add_op(4);
			wait_sent(3000);
		end
		drain(3000, "long random run");
		check_count("in_credit pulses", sent, credit_pulses);
		check_count("commits", sent, commits);
		finish_test("long random run", err0);

		$display("tests %0d, failed %0d, errors %0d, ops %0d", tests_run, tests_failed,
			errors, sent);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/rv_types_pkg.sv
design/ooo_pkg.sv
design/sync_fifo.sv
design/rob.sv
design/alu_unit.sv
design/branch_unit.sv
design/lsq_unit.sv
design/ooo_core.sv
tests/tb_ooo_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ooo_core -o tb_ooo_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_ooo_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
exit 0
